//--- source/stream_params.svh
// ----------------------------------------------------------------------
// Widths, depths and thresholds of the stream compute unit
// STREAM_FIFO_DEPTH must be a power of two
// STREAM_CREDIT_W must hold STREAM_WTBUF_CREDITS
// ----------------------------------------------------------------------
`ifndef STREAM_PARAMS_SVH
`define STREAM_PARAMS_SVH

// Memory side word and address
`define STREAM_ADDR_W 32
`define STREAM_DATA_W 32
`define STREAM_STRB_W 4

// Engine packet fields
`define STREAM_OFFSET_W 16
`define STREAM_ID_W 8

// Request and response FIFO geometry
`define STREAM_FIFO_DEPTH 16
`define STREAM_PROG_THRESH 12

// Writes allowed while the write buffer still holds data
`define STREAM_WTBUF_CREDITS 4
`define STREAM_CREDIT_W 3

`endif

//--- source/stream_cu_pkg.sv
// ----------------------------------------------------------------------
// Engine side types: descriptor, packets, FIFO flags, command FSM
// Response packets travel through the FIFO without their valid bit
// ----------------------------------------------------------------------
`include "stream_params.svh"

package stream_cu_pkg;

  // Packet command
  typedef enum logic [1:0] {
    CMD_MEM_READ  = 2'd0,
    CMD_MEM_WRITE = 2'd1
  } stream_cmd_e;

  // Kernel descriptor, base address of the working buffer
  typedef struct packed {
    logic                      valid;
    logic [`STREAM_ADDR_W-1:0] base_addr;
  } kernel_descriptor_t;

  // Request packet from the engine, offset counts data words
  typedef struct packed {
    logic                        valid;
    stream_cmd_e                 cmd;
    logic [`STREAM_ID_W-1:0]     id;
    logic [`STREAM_OFFSET_W-1:0] offset;
    logic [`STREAM_DATA_W-1:0]   data;
  } mem_packet_req_t;

  // Response packet back to the engine
  typedef struct packed {
    logic                      valid;
    stream_cmd_e               cmd;
    logic [`STREAM_ID_W-1:0]   id;
    logic [`STREAM_DATA_W-1:0] data;
  } mem_packet_rsp_t;

  // Response FIFO entry, the packet minus valid
  localparam int RSP_ENTRY_W = $bits(mem_packet_rsp_t) - 1;

  // FIFO flags
  typedef struct packed {
    logic full;
    logic empty;
    logic prog_full;
  } fifo_status_t;

  // Command FSM
  typedef enum logic [1:0] {
    STREAM_CMD_RESET,
    STREAM_CMD_READY,
    STREAM_CMD_READ,
    STREAM_CMD_WRITE
  } stream_cmd_state_e;

endpackage : stream_cu_pkg

//--- source/stream_mem_pkg.sv
// ----------------------------------------------------------------------
// Memory port request and response types
// cmd and id ride along as metadata, the memory may ignore them
// ----------------------------------------------------------------------
`include "stream_params.svh"

package stream_mem_pkg;
  import stream_cu_pkg::*;

  // Request FIFO entry, the memory request minus valid
  typedef struct packed {
    logic [`STREAM_ADDR_W-1:0] addr;
    logic [`STREAM_DATA_W-1:0] wdata;
    logic [`STREAM_STRB_W-1:0] wstrb;
    stream_cmd_e               cmd;
    logic [`STREAM_ID_W-1:0]   id;
  } mem_req_entry_t;

  // Memory request as seen on the port
  typedef struct packed {
    logic                      valid;
    logic [`STREAM_ADDR_W-1:0] addr;
    logic [`STREAM_DATA_W-1:0] wdata;
    logic [`STREAM_STRB_W-1:0] wstrb;
    stream_cmd_e               cmd;
    logic [`STREAM_ID_W-1:0]   id;
  } mem_req_t;

  // Memory response, ready is a level and rvalid ends a read
  typedef struct packed {
    logic [`STREAM_DATA_W-1:0] rdata;
    logic                      rvalid;
    logic                      ready;
  } mem_rsp_t;

endpackage : stream_mem_pkg

//--- source/stream_sync_fifo.sv
// ----------------------------------------------------------------------
// Synchronous FIFO, first word falls through to dout_o
// Depth and programmable-full threshold come from the params header
// Writes when full and reads when empty are dropped
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "stream_params.svh"

module stream_sync_fifo import stream_cu_pkg::*; #(
  parameter int WIDTH = 32
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             rd_en_i,
  output logic [WIDTH-1:0] dout_o,
  output fifo_status_t     status_o
);

  localparam int DEPTH = `STREAM_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_ok;
  logic             rd_ok;

  // Guarded strobes
  assign wr_ok = wr_en_i & ~status_o.full;
  assign rd_ok = rd_en_i & ~status_o.empty;

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // Head word, no read latency
  assign dout_o = mem[rd_ptr];

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on the power-of-two depth
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Flags straight off the count
  assign status_o.full      = (count == CNT_W'(DEPTH));
  assign status_o.empty     = (count == '0);
  assign status_o.prog_full = (count >= CNT_W'(`STREAM_PROG_THRESH));

  // Upstream must honour the flags
  assert property (@(posedge ap_clk) disable iff (areset_control)
    wr_en_i |-> !status_o.full)
    else $error("stream_sync_fifo: write while full");

  assert property (@(posedge ap_clk) disable iff (areset_control)
    rd_en_i |-> !status_o.empty)
    else $error("stream_sync_fifo: read while empty");

endmodule : stream_sync_fifo

//--- source/stream_request_intake.sv
// ----------------------------------------------------------------------
// Descriptor latch and two-stage request pipeline
// Address is base plus word offset times 4 and strobes are zero on reads
// A packet reaches req_push_o two cycles after request_i
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "stream_params.svh"

module stream_request_intake import stream_cu_pkg::*, stream_mem_pkg::*; (
  input  logic               ap_clk,
  input  logic               areset_control,
  input  kernel_descriptor_t descriptor_i,
  input  mem_packet_req_t    request_i,
  output logic               req_push_o,
  output mem_req_entry_t     req_entry_o
);

  localparam int PAD_W = `STREAM_ADDR_W - `STREAM_OFFSET_W - 2;

  logic [`STREAM_ADDR_W-1:0] base_q;
  mem_packet_req_t           req_s1;
  logic [`STREAM_ADDR_W-1:0] byte_offset;

  // ----------------------------------------------------------------------
  // Base address held until the next valid descriptor
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      base_q <= '0;
    end else if (descriptor_i.valid) begin
      base_q <= descriptor_i.base_addr;
    end
  end

  // ----------------------------------------------------------------------
  // Stage 1 holds the raw packet
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      req_s1.valid <= 1'b0;
    end else begin
      req_s1 <= request_i;
    end
  end

  // Word offset to byte offset
  assign byte_offset = {{PAD_W{1'b0}}, req_s1.offset, 2'b00};

  // ----------------------------------------------------------------------
  // Stage 2 maps the packet to a memory request
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      req_push_o <= 1'b0;
    end else begin
      req_push_o <= req_s1.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    req_entry_o.addr  <= base_q + byte_offset;
    req_entry_o.wdata <= req_s1.data;
    // All lanes on a write and none on a read
    req_entry_o.wstrb <= {`STREAM_STRB_W{req_s1.cmd == CMD_MEM_WRITE}};
    req_entry_o.cmd   <= req_s1.cmd;
    req_entry_o.id    <= req_s1.id;
  end

endmodule : stream_request_intake

//--- source/stream_command_engine.sv
// ----------------------------------------------------------------------
// Command FSM, one memory request in flight at a time
// Reads wait for rvalid, writes take one cycle
// Memory must keep ready high while a request is valid
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "stream_params.svh"

module stream_command_engine import stream_cu_pkg::*, stream_mem_pkg::*; (
  input  logic            ap_clk,
  input  logic            areset_control,
  input  logic            desc_valid_i,
  input  mem_req_entry_t  req_head_i,
  input  fifo_status_t    req_status_i,
  input  fifo_status_t    rsp_status_i,
  input  mem_rsp_t        mem_rsp_i,
  input  logic            wtb_empty_i,
  output mem_req_t        mem_req_o,
  output logic            req_pop_o,
  output logic            rsp_push_o,
  output mem_packet_rsp_t rsp_packet_o
);

  localparam logic [`STREAM_CREDIT_W-1:0] CREDITS = `STREAM_WTBUF_CREDITS;

  stream_cmd_state_e            state_q;
  stream_cmd_state_e            state_d;
  logic [`STREAM_CREDIT_W-1:0] credit_q;
  logic                         head_ok;
  logic                         read_go;
  logic                         write_go;
  logic                         write_issue;

  // ----------------------------------------------------------------------
  // Issue conditions
  // ----------------------------------------------------------------------
  // Head present, room for the response, memory idle, descriptor known
  assign head_ok = mem_rsp_i.ready & ~req_status_i.empty & ~rsp_status_i.prog_full
                   & desc_valid_i;
  assign read_go = head_ok & (req_head_i.cmd == CMD_MEM_READ);
  // Writes also need a credit or a drained write buffer
  assign write_go = head_ok & (req_head_i.cmd == CMD_MEM_WRITE)
                    & ((credit_q != '0) | wtb_empty_i);

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state_q <= STREAM_CMD_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      STREAM_CMD_RESET: state_d = STREAM_CMD_READY;
      STREAM_CMD_READY: begin
        if (read_go) begin
          state_d = STREAM_CMD_READ;
        end else if (write_go) begin
          state_d = STREAM_CMD_WRITE;
        end
      end
      STREAM_CMD_READ: begin
        // Variable latency, rvalid closes it
        if (mem_rsp_i.rvalid) begin
          state_d = STREAM_CMD_READY;
        end
      end
      STREAM_CMD_WRITE: state_d = STREAM_CMD_READY;
      default:          state_d = STREAM_CMD_RESET;
    endcase
  end

  assign write_issue = (state_q == STREAM_CMD_WRITE);

  // ----------------------------------------------------------------------
  // Memory request and FIFO strobes
  // ----------------------------------------------------------------------
  always_comb begin
    mem_req_o.valid = write_issue | ((state_q == STREAM_CMD_READ) & ~mem_rsp_i.rvalid);
    mem_req_o.addr  = req_head_i.addr;
    mem_req_o.wdata = req_head_i.wdata;
    mem_req_o.wstrb = req_head_i.wstrb;
    mem_req_o.cmd   = req_head_i.cmd;
    mem_req_o.id    = req_head_i.id;
  end

  // Pop and push together, once per finished command
  assign req_pop_o  = write_issue | ((state_q == STREAM_CMD_READ) & mem_rsp_i.rvalid);
  assign rsp_push_o = req_pop_o;

  // Response echoes the head, data from memory on reads
  always_comb begin
    rsp_packet_o.valid = rsp_push_o;
    rsp_packet_o.cmd   = req_head_i.cmd;
    rsp_packet_o.id    = req_head_i.id;
    if (req_head_i.cmd == CMD_MEM_READ) begin
      rsp_packet_o.data = mem_rsp_i.rdata;
    end else begin
      rsp_packet_o.data = req_head_i.wdata;
    end
  end

  // ----------------------------------------------------------------------
  // Write buffer credits
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      credit_q <= CREDITS;
    end else if (wtb_empty_i) begin
      // Drained buffer refills the pool, minus a write going out now
      credit_q <= CREDITS - {{(`STREAM_CREDIT_W-1){1'b0}}, write_issue};
    end else if (write_issue) begin
      credit_q <= credit_q - 1'b1;
    end
  end

  // Memory side contract
  assert property (@(posedge ap_clk) disable iff (areset_control)
    mem_req_o.valid |-> mem_rsp_i.ready)
    else $error("stream_command_engine: request without ready");

  // Issue decision a cycle earlier must have left a credit
  assert property (@(posedge ap_clk) disable iff (areset_control)
    write_issue |-> (credit_q != '0) || wtb_empty_i)
    else $error("stream_command_engine: write credit underflow");

endmodule : stream_command_engine

//--- source/cu_stream_top.sv
// ----------------------------------------------------------------------
// Stream compute unit top level
// Request source must stop while request_status_o.prog_full is high
// response_o lags the pop strobe by two cycles, done_o by two cycles
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module cu_stream_top import stream_cu_pkg::*, stream_mem_pkg::*; (
  input  logic               ap_clk,
  input  logic               areset_control,
  input  kernel_descriptor_t descriptor_i,
  input  mem_packet_req_t    request_i,
  output fifo_status_t       request_status_o,
  input  logic               response_pop_i,
  output mem_packet_rsp_t    response_o,
  output fifo_status_t       response_status_o,
  output mem_req_t           mem_req_o,
  input  mem_rsp_t           mem_rsp_i,
  input  logic               wtb_empty_i,
  output logic               done_o
);

  localparam int REQ_ENTRY_W = $bits(mem_req_entry_t);
  localparam fifo_status_t STATUS_EMPTY = '{full: 1'b0, empty: 1'b1, prog_full: 1'b0};

  logic                   desc_valid_q;
  logic                   req_push;
  mem_req_entry_t         req_entry;
  mem_req_entry_t         req_head;
  fifo_status_t           req_status;
  logic                   req_pop;
  logic                   rsp_push;
  mem_packet_rsp_t        rsp_packet;
  logic [RSP_ENTRY_W-1:0] rsp_dout;
  fifo_status_t           rsp_status;
  logic                   pop_q;
  logic                   idle;
  logic                   idle_q;

  // Descriptor seen at least once
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      desc_valid_q <= 1'b0;
    end else begin
      desc_valid_q <= desc_valid_q | descriptor_i.valid;
    end
  end

  stream_request_intake stream_request_intake_inst (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .descriptor_i  (descriptor_i),
    .request_i     (request_i),
    .req_push_o    (req_push),
    .req_entry_o   (req_entry)
  );

  // ----------------------------------------------------------------------
  // Request and response FIFOs
  // ----------------------------------------------------------------------
  stream_sync_fifo #(.WIDTH(REQ_ENTRY_W)) req_fifo_inst (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en_i       (req_push),
    .din_i         (req_entry),
    .rd_en_i       (req_pop),
    .dout_o        (req_head),
    .status_o      (req_status)
  );

  // Valid bit dropped on entry, rebuilt from empty on exit
  stream_sync_fifo #(.WIDTH(RSP_ENTRY_W)) rsp_fifo_inst (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en_i       (rsp_push),
    .din_i         (rsp_packet[RSP_ENTRY_W-1:0]),
    .rd_en_i       (pop_q & ~rsp_status.empty),
    .dout_o        (rsp_dout),
    .status_o      (rsp_status)
  );

  stream_command_engine stream_command_engine_inst (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .desc_valid_i  (desc_valid_q),
    .req_head_i    (req_head),
    .req_status_i  (req_status),
    .rsp_status_i  (rsp_status),
    .mem_rsp_i     (mem_rsp_i),
    .wtb_empty_i   (wtb_empty_i),
    .mem_req_o     (mem_req_o),
    .req_pop_o     (req_pop),
    .rsp_push_o    (rsp_push),
    .rsp_packet_o  (rsp_packet)
  );

  // ----------------------------------------------------------------------
  // Output registers and done
  // ----------------------------------------------------------------------
  // Nothing queued, memory idle, write buffer drained
  assign idle = req_status.empty & rsp_status.empty & mem_rsp_i.ready & wtb_empty_i;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      pop_q             <= 1'b0;
      idle_q            <= 1'b0;
      done_o            <= 1'b0;
      response_o.valid  <= 1'b0;
      request_status_o  <= STATUS_EMPTY;
      response_status_o <= STATUS_EMPTY;
    end else begin
      pop_q             <= response_pop_i;
      idle_q            <= idle;
      done_o            <= idle_q;
      response_o        <= mem_packet_rsp_t'({~rsp_status.empty, rsp_dout});
      request_status_o  <= req_status;
      response_status_o <= rsp_status;
    end
  end

endmodule : cu_stream_top

//--- test/stream_checker.sv
// ----------------------------------------------------------------------
// Checker for cu_stream_top that samples every port on the falling edge
// Assumes in-order service and reads only of offsets written earlier
// Pops must leave two idle cycles for response_o to catch up
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "stream_params.svh"

module stream_checker import stream_cu_pkg::*, stream_mem_pkg::*; (
  input  logic               ap_clk,
  input  logic               areset_control,
  input  kernel_descriptor_t descriptor_i,
  input  mem_packet_req_t    request_i,
  input  logic               response_pop_i,
  input  mem_packet_rsp_t    response_i,
  input  mem_req_t           mem_req_i,
  input  logic               wtb_empty_i,
  input  fifo_status_t       req_status_i,
  input  fifo_status_t       rsp_status_i,
  input  logic               done_i,
  input  logic               final_check_i,
  output int                 error_count_o,
  output int                 rsp_checked_o,
  output int                 outstanding_o
);

  localparam fifo_status_t EMPTY_STATUS = '{full: 1'b0, empty: 1'b1, prog_full: 1'b0};

  logic [`STREAM_ADDR_W-1:0] base_addr;
  logic [`STREAM_DATA_W-1:0] shadow [256];
  mem_packet_req_t           issue_q[$];
  mem_packet_rsp_t           rsp_q[$];
  logic                      req_valid_q;
  logic                      done_seen;
  int                        holdoff;
  int                        write_run;
  int                        since_reset;

  // Expected response of one packet given all earlier writes
  function automatic mem_packet_rsp_t expected_response(input mem_packet_req_t pkt);
    mem_packet_rsp_t rsp;
    rsp.valid = 1'b1;
    rsp.cmd   = pkt.cmd;
    rsp.id    = pkt.id;
    if (pkt.cmd == CMD_MEM_WRITE) begin
      rsp.data = pkt.data;
    end else begin
      rsp.data = shadow[pkt.offset[7:0]];
    end
    return rsp;
  endfunction

  task automatic flag_mismatch(input string what);
    error_count_o++;
    $display("CHECK FAILED at %0t: %s", $time, what);
  endtask

  task automatic flag_error(input string what);
    error_count_o++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  always @(negedge ap_clk) begin : compare_proc
    mem_packet_req_t           pkt;
    mem_packet_rsp_t           exp;
    logic [`STREAM_ADDR_W-1:0] exp_addr;
    logic [`STREAM_STRB_W-1:0] exp_strb;
    if (areset_control) begin
      issue_q.delete();
      rsp_q.delete();
      req_valid_q = 1'b0;
      done_seen   = 1'b0;
      holdoff     = 0;
      write_run   = 0;
      since_reset = 0;
    end else begin
      // Outputs stay quiet until the first done which must come quickly
      if (!done_seen) begin
        since_reset++;
        if (response_i.valid || mem_req_i.valid) begin
          flag_mismatch("valid output before the first done_o");
        end
        if (done_i) begin
          done_seen = 1'b1;
        end else if (since_reset > 3) begin
          flag_error("done_o did not rise within 3 cycles of reset release");
          done_seen = 1'b1;
        end
      end
      if (descriptor_i.valid) begin
        base_addr = descriptor_i.base_addr;
      end
      // Expected response is fixed at arrival as the shadow follows request order
      if (request_i.valid) begin
        issue_q.push_back(request_i);
        rsp_q.push_back(expected_response(request_i));
        if (request_i.cmd == CMD_MEM_WRITE) begin
          shadow[request_i.offset[7:0]] = request_i.data;
        end
      end
      // ------------------------------------------------------------------
      // One memory request per rising edge of valid
      // ------------------------------------------------------------------
      if (wtb_empty_i) begin
        write_run = 0;
      end
      if (mem_req_i.valid && !req_valid_q) begin
        if (issue_q.size() == 0) begin
          flag_error("memory request with no packet outstanding");
        end else begin
          pkt      = issue_q.pop_front();
          exp_addr = base_addr + {pkt.offset, 2'b00};
          exp_strb = (pkt.cmd == CMD_MEM_WRITE) ? {`STREAM_STRB_W{1'b1}} : '0;
          if (mem_req_i.addr !== exp_addr || mem_req_i.wstrb !== exp_strb) begin
            flag_mismatch($sformatf("id %0d addr %h strb %b, expected addr %h strb %b",
                                    pkt.id, mem_req_i.addr, mem_req_i.wstrb, exp_addr,
                                    exp_strb));
          end
          if (mem_req_i.cmd !== pkt.cmd || mem_req_i.id !== pkt.id ||
              (pkt.cmd == CMD_MEM_WRITE && mem_req_i.wdata !== pkt.data)) begin
            flag_mismatch($sformatf("request id %0d cmd %0d data %h, expected id %0d",
                                    mem_req_i.id, mem_req_i.cmd, mem_req_i.wdata, pkt.id));
          end
        end
        // Writes since the write buffer was last seen empty
        if (mem_req_i.cmd == CMD_MEM_WRITE) begin
          write_run++;
          if (write_run > `STREAM_WTBUF_CREDITS) begin
            flag_error("more writes issued than write buffer credits");
          end
        end
      end
      req_valid_q = mem_req_i.valid;
      // ------------------------------------------------------------------
      // Responses compared on the pop strobe
      // ------------------------------------------------------------------
      if (response_pop_i) begin
        if (rsp_q.size() == 0) begin
          flag_error("response with no packet outstanding");
        end else begin
          exp = rsp_q.pop_front();
          rsp_checked_o++;
          if (response_i !== exp) begin
            flag_mismatch($sformatf("response id %0d cmd %0d data %h, expected %0d %0d %h",
                                    response_i.id, response_i.cmd, response_i.data,
                                    exp.id, exp.cmd, exp.data));
          end
        end
        holdoff = 2;
      end else if (holdoff != 0) begin
        // Old head still on response_o
        holdoff--;
      end else if (response_i.valid && rsp_q.size() == 0) begin
        flag_mismatch("response_o valid with no packet outstanding");
      end
      // Drained unit
      if (final_check_i) begin
        if (!done_i || req_status_i !== EMPTY_STATUS || rsp_status_i !== EMPTY_STATUS) begin
          flag_mismatch($sformatf("drained done %b request status %b response status %b",
                                  done_i, req_status_i, rsp_status_i));
        end
        if (issue_q.size() != 0 || rsp_q.size() != 0) begin
          flag_error("packets still outstanding after the unit drained");
        end
      end
      outstanding_o = rsp_q.size();
    end
  end

endmodule : stream_checker

//--- test/tb_cu_stream.sv
// ----------------------------------------------------------------------
// Testbench for cu_stream_top with a behavioral memory and a checker
// Memory holds 256 words, address bits 9:2 select the word
// Stimulus reads only offsets 0 to 15 after writing all of them
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "stream_params.svh"

module tb_cu_stream
  import stream_cu_pkg::*, stream_mem_pkg::*;
();

  localparam logic [`STREAM_ADDR_W-1:0] BASE_ADDR = 32'h4000_1400;
  localparam int NUM_PACKETS = 52;
  localparam int CYCLE_LIMIT = 40 * NUM_PACKETS + 200;

  logic                     ap_clk;
  logic                     areset_control;
  kernel_descriptor_t       descriptor;
  mem_packet_req_t          request;
  fifo_status_t             request_status;
  logic                     response_pop = 1'b0;
  mem_packet_rsp_t          response;
  fifo_status_t             response_status;
  mem_req_t                 mem_req;
  mem_rsp_t                 mem_rsp = '{rdata: '0, rvalid: 1'b0, ready: 1'b1};
  logic                     wtb_empty = 1'b1;
  logic                     done;
  logic                     final_check;
  int                       error_count;
  int                       rsp_checked;
  int                       outstanding;
  int                       cycles;
  logic [`STREAM_ID_W-1:0]  next_id;
  // Memory model state
  logic [`STREAM_DATA_W-1:0] mem_words [256];
  logic [7:0]               rd_index;
  logic                     rd_busy = 1'b0;
  int                       rd_wait;
  int                       wtb_wait = 0;
  logic                     hold_wtb = 1'b0;
  int                       pop_holdoff;

  initial ap_clk = 1'b0;
  always #50 ap_clk = ~ap_clk;

  cu_stream_top cu_stream_top_inst (
    .ap_clk           (ap_clk),
    .areset_control   (areset_control),
    .descriptor_i     (descriptor),
    .request_i        (request),
    .request_status_o (request_status),
    .response_pop_i   (response_pop),
    .response_o       (response),
    .response_status_o(response_status),
    .mem_req_o        (mem_req),
    .mem_rsp_i        (mem_rsp),
    .wtb_empty_i      (wtb_empty),
    .done_o           (done)
  );

  stream_checker stream_checker_inst (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .descriptor_i  (descriptor),
    .request_i     (request),
    .response_pop_i(response_pop),
    .response_i    (response),
    .mem_req_i     (mem_req),
    .wtb_empty_i   (wtb_empty),
    .req_status_i  (request_status),
    .rsp_status_i  (response_status),
    .done_i        (done),
    .final_check_i (final_check),
    .error_count_o (error_count),
    .rsp_checked_o (rsp_checked),
    .outstanding_o (outstanding)
  );

  // ----------------------------------------------------------------------
  // Memory model, reads take 1 to 4 cycles, writes one
  // ----------------------------------------------------------------------
  always @(posedge ap_clk) begin : memory_model
    mem_req_t req_now;
    int       b;
    #1;
    req_now = mem_req;
    mem_rsp.rvalid = 1'b0;
    // Write buffer drains on its own unless held busy
    if (wtb_wait > 0) begin
      wtb_wait--;
    end
    if (!wtb_empty && wtb_wait == 0 && !hold_wtb) begin
      wtb_empty = 1'b1;
    end
    if (rd_busy) begin
      rd_wait--;
      if (rd_wait == 0) begin
        mem_rsp.rvalid = 1'b1;
        mem_rsp.rdata  = mem_words[rd_index];
        rd_busy        = 1'b0;
      end
    end else if (req_now.valid && req_now.cmd == CMD_MEM_READ) begin
      rd_busy  = 1'b1;
      rd_wait  = 1 + $urandom % 4;
      rd_index = req_now.addr[9:2];
    end else if (req_now.valid) begin
      for (b = 0; b < `STREAM_STRB_W; b++) begin
        if (req_now.wstrb[b]) begin
          mem_words[req_now.addr[9:2]][8*b +: 8] = req_now.wdata[8*b +: 8];
        end
      end
      wtb_empty = 1'b0;
      wtb_wait  = 1 + $urandom % 6;
    end
  end

  // Pops at random, two quiet cycles after each
  always @(posedge ap_clk) begin : response_drain
    #1;
    response_pop = 1'b0;
    if (areset_control) begin
      pop_holdoff = 0;
    end else if (pop_holdoff > 0) begin
      pop_holdoff--;
    end else if (response.valid && ($urandom % 4 != 0)) begin
      response_pop = 1'b1;
      pop_holdoff  = 2;
    end
  end

  always @(posedge ap_clk) begin : watchdog
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors: %0d, responses checked: %0d", error_count, rsp_checked);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // One packet per cycle, stalls while the request FIFO is nearly full
  task automatic send_packet(input stream_cmd_e cmd, input int offset,
                             input logic [`STREAM_DATA_W-1:0] data);
    while (request_status.prog_full) begin
      @(posedge ap_clk);
      #1;
    end
    request.valid  = 1'b1;
    request.cmd    = cmd;
    request.id     = next_id;
    request.offset = 16'(offset);
    request.data   = data;
    next_id++;
    @(posedge ap_clk);
    #1;
    request.valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (outstanding != 0 || !done) begin
      @(posedge ap_clk);
      #1;
    end
  endtask

  task automatic hold_write_buffer(input logic busy);
    @(negedge ap_clk);
    hold_wtb = busy;
    @(posedge ap_clk);
    #1;
  endtask

  initial begin : stimulus
    int i;
    void'($urandom(32'he843));
    areset_control = 1'b1;
    descriptor     = '0;
    request        = '0;
    final_check    = 1'b0;
    next_id        = '0;
    cycles         = 0;
    for (i = 0; i < 256; i++) begin
      mem_words[i] = (BASE_ADDR | 32'(i << 2)) ^ 32'h5a5a_5a5a;
    end
    repeat (3) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;
    // Idle unit reports done without traffic
    wait_idle();
    descriptor = '{valid: 1'b1, base_addr: BASE_ADDR};
    @(posedge ap_clk);
    #1;
    descriptor.valid = 1'b0;
    for (i = 0; i < 16; i++) begin
      send_packet(CMD_MEM_WRITE, i, $urandom);
    end
    // Read back right after the write
    send_packet(CMD_MEM_WRITE, 3, 32'hc0de_0003);
    send_packet(CMD_MEM_READ, 3, 32'h0);
    send_packet(CMD_MEM_WRITE, 9, 32'hc0de_0009);
    send_packet(CMD_MEM_READ, 9, 32'h0);
    for (i = 0; i < 24; i++) begin
      send_packet(stream_cmd_e'($urandom % 2), $urandom % 16, $urandom);
    end
    wait_idle();
    // Write buffer held busy, credits run out
    hold_write_buffer(1'b1);
    for (i = 0; i < 8; i++) begin
      send_packet(CMD_MEM_WRITE, i, $urandom);
    end
    repeat (30) @(posedge ap_clk);
    #1;
    hold_write_buffer(1'b0);
    wait_idle();
    final_check = 1'b1;
    @(posedge ap_clk);
    #1;
    final_check = 1'b0;
    @(posedge ap_clk);
    $display("Errors: %0d, responses checked: %0d of %0d", error_count, rsp_checked,
             NUM_PACKETS);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : tb_cu_stream

//--- tb.f
+incdir+source
source/stream_cu_pkg.sv
source/stream_mem_pkg.sv
source/stream_sync_fifo.sv
source/stream_request_intake.sv
source/stream_command_engine.sv
source/cu_stream_top.sv
test/stream_checker.sv
test/tb_cu_stream.sv
